// File: filelist.f
src/csr_pkg.sv
src/hpm_counter64.sv
src/csr_config_regs.sv
src/csr_access.sv
src/csr_top.sv
verification/csr_tb.sv

// File: Makefile
SRCS = src/csr_pkg.sv src/hpm_counter64.sv src/csr_config_regs.sv \
       src/csr_access.sv src/csr_top.sv verification/csr_tb.sv

.PHONY: run clean

run: obj_dir/Vcsr_tb
	./obj_dir/Vcsr_tb | tee sim.log
	grep -q "^Finished with no errors$$" sim.log

obj_dir/Vcsr_tb: filelist.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module csr_tb -Mdir obj_dir -f filelist.f

clean:
	rm -rf obj_dir sim.log

// File: verification/csr_tb.sv
/* CSR unit testbench
   Reference model of counters and config registers, checked by assertions */

`timescale 1ns/1ps
`default_nettype none

module csr_tb
    import csr_pkg::*;
;

    localparam int MAX_CYCLES = 2000;
    localparam csr_addr_t UNKNOWN_ADDR = 12'h7C0;

    logic      clk;
    logic      rstz;
    csr_addr_t addr;
    csr_op_e   op;
    csr_data_t wr_data;
    logic      rd_req;
    logic      wr_req;
    logic      instret;
    csr_data_t rd_data;
    logic      gnt;

    // Reference model state
    count_t    m_cycle;
    count_t    m_instret;
    logic      m_cy_pend;
    logic      m_ir_pend;
    csr_data_t m_inhibit;
    csr_data_t m_scratch;
    csr_data_t exp_rd;
    logic      exp_gnt;
    logic      was_rd;
    logic      m_we;
    csr_data_t m_wdata;
    logic      cy_inc;
    logic      ir_inc;

    integer    seed;
    int        cycles;
    int        gnt_errors;
    int        data_errors;
    csr_data_t inst_pat;
    csr_data_t r;
    csr_data_t d;
    csr_data_t hi_val;
    csr_addr_t a;

    csr_top u_dut (
        .clk     (clk),
        .rstz    (rstz),
        .addr    (addr),
        .op      (op),
        .wr_data (wr_data),
        .rd_req  (rd_req),
        .wr_req  (wr_req),
        .instret (instret),
        .rd_data (rd_data),
        .gnt     (gnt)
    );

    always #5 clk = ~clk;

    // ========================================
    // Reference model

    // Load of a half wins over the increment, carry shows in the full value at once
    function automatic count_t next_count(count_t c, logic inc, logic ld_lo, logic ld_hi,
                                          csr_data_t wd);
        count_t n;
        n = c + {63'd0, inc};
        if (ld_lo) begin
            n = {c[63:32], wd};
        end else if (ld_hi) begin
            n = {wd, c[31:0]} + {63'd0, inc};
        end
        return n;
    endfunction

    function automatic csr_data_t read_model(csr_addr_t ra);
        case (ra)
            MCYCLE        : return m_cycle[31:0];
            MCYCLEH       : return m_cycle[63:32];
            MINSTRET      : return m_instret[31:0];
            MINSTRETH     : return m_instret[63:32];
            MCOUNTINHIBIT : return m_inhibit;
            MSCRATCH      : return m_scratch;
            default       : return '0;
        endcase
    endfunction

    // Read wins over write; set and clear act on the last read value
    assign m_we   = wr_req && !rd_req;
    assign cy_inc = !m_inhibit[INHIBIT_CY];
    assign ir_inc = instret && !m_inhibit[INHIBIT_IR];

    always_comb begin
        case (op)
            CSR_RS  : m_wdata = exp_rd | wr_data;
            CSR_RC  : m_wdata = exp_rd & ~wr_data;
            default : m_wdata = wr_data;
        endcase
    end

    always @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            m_cycle   <= '0;
            m_instret <= '0;
            m_cy_pend <= 1'b0;
            m_ir_pend <= 1'b0;
            m_inhibit <= '0;
            m_scratch <= '0;
            exp_rd    <= '0;
            exp_gnt   <= 1'b0;
            was_rd    <= 1'b0;
        end else begin
            m_cycle   <= next_count(m_cycle, cy_inc, m_we && addr == MCYCLE,
                                    m_we && addr == MCYCLEH, m_wdata);
            m_instret <= next_count(m_instret, ir_inc, m_we && addr == MINSTRET,
                                    m_we && addr == MINSTRETH, m_wdata);
            // Carry in flight for one cycle after a low-half wrap
            m_cy_pend <= !(m_we && addr == MCYCLE) && cy_inc && (&m_cycle[31:0]);
            m_ir_pend <= !(m_we && addr == MINSTRET) && ir_inc && (&m_instret[31:0]);
            if (m_we && addr == MCOUNTINHIBIT) begin
                // Only CY and IR stick
                m_inhibit <= m_wdata & 32'h0000_0005;
            end
            if (m_we && addr == MSCRATCH) begin
                m_scratch <= m_wdata;
            end
            if (rd_req) begin
                exp_rd <= read_model(addr);
            end
            exp_gnt <= rd_req ? !(m_cy_pend || m_ir_pend) : wr_req;
            was_rd  <= rd_req;
        end
    end

    // ========================================
    // Checks, sampled mid-cycle

    a_gnt_match: assert property (@(negedge clk) disable iff (!rstz) gnt == exp_gnt)
        else begin
            gnt_errors = gnt_errors + 1;
            $display("** Error at %0t: gnt = %0b, expected %0b", $time, gnt, exp_gnt);
        end

    a_rd_match: assert property (@(negedge clk) disable iff (!rstz)
        (gnt && was_rd) |-> rd_data == exp_rd)
        else begin
            data_errors = data_errors + 1;
            $display("** Error at %0t: rd_data = %h, expected %h", $time, rd_data, exp_rd);
        end

    // ========================================
    // Stimulus

    // Rotating instret pattern
    always @(negedge clk) begin
        if (rstz) begin
            instret  = inst_pat[0];
            inst_pat = {inst_pat[0], inst_pat[31:1]};
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the test sequence did not complete", MAX_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // Hold rd_req until the grant
    task automatic read_csr(input csr_addr_t ra);
        addr   = ra;
        rd_req = 1'b1;
        @(negedge clk);
        while (!gnt) @(negedge clk);
        rd_req = 1'b0;
        @(negedge clk);
    endtask

    task automatic write_csr(input csr_addr_t wa, input csr_op_e wo, input csr_data_t wd);
        addr    = wa;
        op      = wo;
        wr_data = wd;
        wr_req  = 1'b1;
        @(negedge clk);
        wr_req = 1'b0;
        @(negedge clk);
    endtask

    // Back-to-back reads, catches the carry stall
    task automatic stream_reads(input csr_addr_t ra, input int n);
        addr   = ra;
        rd_req = 1'b1;
        repeat (n) @(negedge clk);
        rd_req = 1'b0;
        @(negedge clk);
    endtask

    function automatic csr_addr_t pick_addr(logic [2:0] k);
        case (k)
            3'd0    : return MCYCLE;
            3'd1    : return MCYCLEH;
            3'd2    : return MINSTRET;
            3'd3    : return MINSTRETH;
            3'd4    : return MCOUNTINHIBIT;
            3'd5    : return MSCRATCH;
            default : return UNKNOWN_ADDR;
        endcase
    endfunction

    initial begin
        clk         = 1'b0;
        rstz        = 1'b0;
        addr        = '0;
        op          = CSR_RW;
        wr_data     = '0;
        rd_req      = 1'b0;
        wr_req      = 1'b0;
        instret     = 1'b0;
        cycles      = 0;
        gnt_errors  = 0;
        data_errors = 0;
        seed        = 32'hed2dd0c7;
        inst_pat    = $random(seed);
        repeat (4) @(negedge clk);
        rstz = 1'b1;

        // Idle after reset, then counter reads
        repeat (3) @(negedge clk);
        read_csr(MCYCLE);
        read_csr(MCYCLEH);

        // mscratch merges and the unknown address
        d = $random(seed);
        write_csr(MSCRATCH, CSR_RW, d);
        read_csr(MSCRATCH);
        d = $random(seed);
        write_csr(MSCRATCH, CSR_RS, d);
        read_csr(MSCRATCH);
        d = $random(seed);
        write_csr(MSCRATCH, CSR_RC, d);
        read_csr(MSCRATCH);
        read_csr(UNKNOWN_ADDR);
        write_csr(UNKNOWN_ADDR, CSR_RW, 32'hFFFF_FFFF);
        read_csr(MSCRATCH);
        read_csr(MCOUNTINHIBIT);

        // Inhibit freezes and resumes each counter
        read_csr(MINSTRET);
        write_csr(MCOUNTINHIBIT, CSR_RW, csr_data_t'(1 << INHIBIT_IR));
        read_csr(MINSTRET);
        read_csr(MINSTRET);
        read_csr(MCOUNTINHIBIT);
        write_csr(MCOUNTINHIBIT, CSR_RC, csr_data_t'(1 << INHIBIT_IR));
        read_csr(MINSTRET);
        read_csr(MCOUNTINHIBIT);
        write_csr(MCOUNTINHIBIT, CSR_RS, csr_data_t'(1 << INHIBIT_CY));
        read_csr(MCYCLE);
        read_csr(MCYCLE);
        write_csr(MCOUNTINHIBIT, CSR_RW, 32'h0);
        read_csr(MCYCLE);
        // Reserved bits read back zero
        write_csr(MCOUNTINHIBIT, CSR_RW, 32'hFFFF_FFFF);
        read_csr(MCOUNTINHIBIT);
        write_csr(MCOUNTINHIBIT, CSR_RW, 32'h0);

        // Low-half wrap with the carry stall
        write_csr(MCYCLE, CSR_RW, 32'hFFFF_FFF0);
        hi_val = $random(seed);
        write_csr(MCYCLEH, CSR_RW, hi_val);
        stream_reads(MCYCLEH, 24);
        read_csr(MCYCLEH);
        a_wrap_hi: assert (rd_data == hi_val + 32'd1)
            else begin
                data_errors = data_errors + 1;
                $display("** Error at %0t: rd_data = %h, expected %h", $time, rd_data,
                         hi_val + 32'd1);
            end

        // Random mix, counters read only
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            a = pick_addr(r[2:0]);
            if (!r[3] && (a inside {MCOUNTINHIBIT, MSCRATCH, UNKNOWN_ADDR})) begin
                d = $random(seed);
                write_csr(a, csr_op_e'(r[5:4]), d);
            end else begin
                read_csr(a);
            end
        end

        repeat (2) @(negedge clk);
        $display("Checks done: %0d handshake errors, %0d data errors", gnt_errors, data_errors);
        if (gnt_errors + data_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/csr_top.sv
/* Machine-level CSR unit top
   Sequencer, configuration registers and the two performance counters */

`timescale 1ns/1ps
`default_nettype none

module csr_top
    import csr_pkg::*;
(
    input  wire            clk,
    input  wire            rstz,
    input  wire csr_addr_t addr,
    input  wire csr_op_e   op,
    input  wire csr_data_t wr_data,
    input  wire            rd_req,
    input  wire            wr_req,
    input  wire            instret,
    output csr_data_t      rd_data,
    output logic           gnt
);

    csr_wr_t   wr_cmd;
    count_t    mcycle;
    count_t    minstret;
    logic      cycle_vld;
    logic      instret_vld;
    csr_data_t mcountinhibit;
    csr_data_t mscratch;
    logic      cycle_incr;
    logic      instret_incr;

    // ========================================
    // Access sequencer

    csr_access u_access (
        .clk           (clk),
        .rstz          (rstz),
        .addr          (addr),
        .op            (op),
        .wr_data       (wr_data),
        .rd_req        (rd_req),
        .wr_req        (wr_req),
        .rd_data       (rd_data),
        .gnt           (gnt),
        .wr_cmd        (wr_cmd),
        .mcycle        (mcycle),
        .minstret      (minstret),
        .cycle_vld     (cycle_vld),
        .instret_vld   (instret_vld),
        .mcountinhibit (mcountinhibit),
        .mscratch      (mscratch)
    );

    csr_config_regs u_config (
        .clk           (clk),
        .rstz          (rstz),
        .wr_cmd        (wr_cmd),
        .mcountinhibit (mcountinhibit),
        .mscratch      (mscratch)
    );

    // ========================================
    // Performance counters

    // Inhibit bits gate each increment
    assign cycle_incr   = !mcountinhibit[INHIBIT_CY];
    assign instret_incr = instret && !mcountinhibit[INHIBIT_IR];

    hpm_counter64 u_mcycle (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (cycle_incr),
        .wr_cmd    (wr_cmd),
        .lo_addr   (MCYCLE),
        .hi_addr   (MCYCLEH),
        .count     (mcycle),
        .count_vld (cycle_vld)
    );

    hpm_counter64 u_minstret (
        .clk       (clk),
        .rstz      (rstz),
        .incr      (instret_incr),
        .wr_cmd    (wr_cmd),
        .lo_addr   (MINSTRET),
        .hi_addr   (MINSTRETH),
        .count     (minstret),
        .count_vld (instret_vld)
    );

endmodule

`default_nettype wire

// File: src/csr_access.sv
/* CSR access sequencer
   Address decode, read mux, RW/RS/RC merge and grant generation */

`timescale 1ns/1ps
`default_nettype none

module csr_access
    import csr_pkg::*;
(
    input  wire            clk,
    input  wire            rstz,
    // Requester side
    input  wire csr_addr_t addr,
    input  wire csr_op_e   op,
    input  wire csr_data_t wr_data,
    input  wire            rd_req,
    input  wire            wr_req,
    output csr_data_t      rd_data,
    output logic           gnt,
    // Write command to all register holders
    output csr_wr_t        wr_cmd,
    // Counter values and their read-valid flags
    input  wire count_t    mcycle,
    input  wire count_t    minstret,
    input  wire            cycle_vld,
    input  wire            instret_vld,
    // Configuration registers
    input  wire csr_data_t mcountinhibit,
    input  wire csr_data_t mscratch
);

    csr_data_t rd_value;
    csr_data_t wr_merged;
    logic      rd_vld;

    // Any counter with a carry in flight holds off the read
    assign rd_vld = cycle_vld && instret_vld;

    // ========================================
    // Read mux

    always_comb begin
        rd_value = '0;
        case (addr)
            MCYCLE        : rd_value = mcycle[31:0];
            MCYCLEH       : rd_value = mcycle[63:32];
            MINSTRET      : rd_value = minstret[31:0];
            MINSTRETH     : rd_value = minstret[63:32];
            MCOUNTINHIBIT : rd_value = mcountinhibit;
            MSCRATCH      : rd_value = mscratch;
            // Unknown address reads zero
            default       : rd_value = '0;
        endcase
    end

    // ========================================
    // Sequencer

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            rd_data <= '0;
            gnt     <= 1'b0;
        end else if (rd_req) begin
            // Capture every read cycle, grant only once valid
            rd_data <= rd_value;
            gnt     <= rd_vld;
        end else if (wr_req) begin
            // Writes are never held off
            gnt <= 1'b1;
        end else begin
            gnt <= 1'b0;
        end
    end

    // ========================================
    // Write merge

    // Set and clear masks apply to the last read value
    always_comb begin
        case (op)
            CSR_RS  : wr_merged = rd_data | wr_data;
            CSR_RC  : wr_merged = rd_data & ~wr_data;
            default : wr_merged = wr_data;
        endcase
    end

    // Read has priority, so no write goes out beside it
    assign wr_cmd.en   = wr_req && !rd_req;
    assign wr_cmd.addr = addr;
    assign wr_cmd.data = wr_merged;

    // Grant only answers a request from the cycle before
    a_gnt_after_req: assert property (
        @(posedge clk) disable iff (!rstz)
        $rose(gnt) |-> $past(rd_req || wr_req)
    );

endmodule

`default_nettype wire

// File: src/csr_config_regs.sv
/* Counter configuration and scratch CSRs
   Holds mcountinhibit and mscratch with their write decode */

`timescale 1ns/1ps
`default_nettype none

module csr_config_regs
    import csr_pkg::*;
(
    input  wire          clk,
    input  wire          rstz,
    input  wire csr_wr_t wr_cmd,
    output csr_data_t    mcountinhibit,
    output csr_data_t    mscratch
);

    logic inhibit_we;
    logic scratch_we;

    // ========================================
    // Write decode

    assign inhibit_we = wr_cmd.en && (wr_cmd.addr == MCOUNTINHIBIT);
    assign scratch_we = wr_cmd.en && (wr_cmd.addr == MSCRATCH);

    // ========================================
    // mcountinhibit

    // Only CY and IR exist here
    // HPM3 and above are not implemented, so their bits stay zero
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            mcountinhibit <= '0;
        end else if (inhibit_we) begin
            mcountinhibit <= wr_cmd.data & INHIBIT_MASK;
        end
    end

    // ========================================
    // mscratch

    // Full 32-bit scratch word for the trap handler
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            mscratch <= '0;
        end else if (scratch_we) begin
            mscratch <= wr_cmd.data;
        end
    end

    // Reserved inhibit bits read zero whatever was written
    a_inhibit_reserved: assert property (
        @(posedge clk) disable iff (!rstz)
        (mcountinhibit & ~INHIBIT_MASK) == '0
    );

endmodule

`default_nettype wire

// File: src/hpm_counter64.sv
/* 64-bit hardware performance counter
   Split 32-bit halves with a registered carry and a read-valid flag */

`timescale 1ns/1ps
`default_nettype none

module hpm_counter64
    import csr_pkg::*;
(
    input  wire            clk,
    input  wire            rstz,
    input  wire            incr,
    input  wire csr_wr_t   wr_cmd,
    input  wire csr_addr_t lo_addr,
    input  wire csr_addr_t hi_addr,
    output count_t         count,
    output logic           count_vld
);

    csr_data_t cnt_lo;
    csr_data_t cnt_hi;
    csr_data_t lo_next;
    logic      lo_wrap;
    logic      carry_q;
    logic      load_lo;
    logic      load_hi;

    // ========================================
    // Write decode

    // Each instance matches its own pair of addresses
    assign load_lo = wr_cmd.en && (wr_cmd.addr == lo_addr);
    assign load_hi = wr_cmd.en && (wr_cmd.addr == hi_addr);

    // ========================================
    // Lower half

    // Only this 32-bit adder sits on the critical path
    assign {lo_wrap, lo_next} = {1'b0, cnt_lo} + 33'd1;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            cnt_lo <= '0;
        end else if (load_lo) begin
            // Load wins over the increment
            cnt_lo <= wr_cmd.data;
        end else if (incr) begin
            cnt_lo <= lo_next;
        end
    end

    // Carry pending for one cycle after a wrap
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            carry_q <= 1'b0;
        end else if (load_lo) begin
            // Fresh low value drops the pending carry
            carry_q <= 1'b0;
        end else begin
            carry_q <= incr && lo_wrap;
        end
    end

    // ========================================
    // Upper half

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            cnt_hi <= '0;
        end else if (load_hi) begin
            cnt_hi <= wr_cmd.data;
        end else if (carry_q) begin
            cnt_hi <= cnt_hi + 32'd1;
        end
    end

    assign count = {cnt_hi, cnt_lo};

    // Upper half is stale while the carry is in flight
    assign count_vld = !carry_q;

    // A carry never stays pending past one edge
    a_vld_single_gap: assert property (
        @(posedge clk) disable iff (!rstz)
        !count_vld |=> count_vld
    );

endmodule

`default_nettype wire

// File: src/csr_pkg.sv
/* Machine-level CSR unit shared definitions
   Data widths, CSR addresses, access operations and the write command */

`default_nettype none

package csr_pkg;

    // ========================================
    // Widths

    // 12-bit CSR address space
    typedef logic [11:0] csr_addr_t;
    // One CSR data word
    typedef logic [31:0] csr_data_t;
    // Full hardware performance counter
    typedef logic [63:0] count_t;

    // Access operation, same coding as funct3[1:0] of the CSR instructions
    // 2'b00 is unnamed and falls through to a plain write
    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_e;

    // ========================================
    // CSR addresses

    localparam csr_addr_t MCYCLE        = 12'hB00;
    localparam csr_addr_t MCYCLEH       = 12'hB80;
    localparam csr_addr_t MINSTRET      = 12'hB02;
    localparam csr_addr_t MINSTRETH     = 12'hB82;
    localparam csr_addr_t MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t MSCRATCH      = 12'h340;

    // mcountinhibit bit positions
    localparam int INHIBIT_CY = 0;
    localparam int INHIBIT_IR = 2;
    // Writable bits of mcountinhibit, all others are hardwired zero
    localparam csr_data_t INHIBIT_MASK = csr_data_t'((1 << INHIBIT_CY) | (1 << INHIBIT_IR));

    // Write command fanned out to every register holder
    // Data is already merged for RS/RC
    typedef struct packed {
        logic      en;
        csr_addr_t addr;
        csr_data_t data;
    } csr_wr_t;

endpackage

`default_nettype wire
